/* alert_cycler.sv */
module alert_cycler
    import lcd_pkg::*;
(
    input  logic        CLOCK_50,
    input  logic        rst,
    input  logic [1:0]  paper_level,
    input  logic [1:0]  bin0_level,
    input  logic [1:0]  bin1_level,
    input  logic [1:0]  nd_level,
    input  logic [1:0]  ch_level,
    input  logic [1:0]  w_pressure,
    input  logic [15:0] err_mask,
    output logic [3:0]  msg_sel
);

    logic [15:0] warn_mask;
    logic [31:0] tick_cnt;
    logic        tick;
    logic        err_present;
    logic        warn_present;
    logic        err_run;        // Error code valid from last tick
    logic        warn_run;
    logic        warn_show;
    logic [3:0]  err_code;
    logic [3:0]  warn_code;
    logic [3:0]  err_code_nxt;
    logic [3:0]  warn_code_nxt;
    logic        warn_show_nxt;

    function automatic logic [3:0] lowest_set(input logic [15:0] m);
        logic [3:0] pos;
        pos = 4'd0;
        for (int i = 15; i >= 0; i--) begin
            if (m[i]) pos = 4'(i);
        end
        return pos;
    endfunction

    // Next set bit above cur, else wrap; restart at lowest if cur has gone
    function automatic logic [3:0] rotate(input logic [15:0] m, input logic [3:0] cur,
                                          input logic run);
        logic [15:0] above;
        above = m & ((16'hFFFF << cur) << 1);
        if (!run || !m[cur] || above == 16'd0) return lowest_set(m);
        return lowest_set(above);
    endfunction

    function automatic logic [3:0] err_msg(input logic [3:0] code);
        case (code)
            E_PAPER_NOT_INST: return MSG_PAPER_NOT_INST;
            E_PAPER_EMPTY:    return MSG_PAPER_EMPTY;
            E_NO_COFFEE0:     return MSG_NO_COFFEE0;
            E_NO_COFFEE1:     return MSG_NO_COFFEE1;
            E_NO_CREAMER:     return MSG_NO_CREAMER;
            E_NO_CHOC:        return MSG_NO_CHOC;
            E_PRESS_ERR:      return MSG_PRESS_ERR;
            E_PRESS_HIGH:     return MSG_PRESS_HIGH;
            default:          return MSG_STATUS_ERR;   // Also catches unknown bits
        endcase
    endfunction

    function automatic logic [3:0] warn_msg(input logic [3:0] code);
        case (code)
            W_LOW_PRESSURE: return MSG_PRESS_LOW;
            W_BIN0_LOW:     return MSG_BIN0_LOW;
            W_BIN1_LOW:     return MSG_BIN1_LOW;
            W_ND_LOW:       return MSG_ND_LOW;
            W_CH_LOW:       return MSG_CH_LOW;
            default:        return MSG_FILTER_ALMOST;
        endcase
    endfunction

    always_comb begin
        warn_mask                  = 16'd0;
        warn_mask[W_FILTER_ALMOST] = (paper_level == LEVEL_ALMOST);
        warn_mask[W_LOW_PRESSURE]  = (w_pressure == PRESSURE_LOW);
        warn_mask[W_BIN0_LOW]      = (bin0_level == LEVEL_ALMOST);
        warn_mask[W_BIN1_LOW]      = (bin1_level == LEVEL_ALMOST);
        warn_mask[W_ND_LOW]        = (nd_level == LEVEL_ALMOST);
        warn_mask[W_CH_LOW]        = (ch_level == LEVEL_ALMOST);
    end

    assign err_present  = |err_mask;
    assign warn_present = |warn_mask;
    assign tick         = (tick_cnt == TICK_CYCLES - 32'd1);

    always_ff @(posedge CLOCK_50) begin
        if (rst || tick) tick_cnt <= 32'd0;
        else tick_cnt <= tick_cnt + 32'd1;
    end

    always_comb begin
        err_code_nxt  = err_code;
        warn_code_nxt = warn_code;
        warn_show_nxt = 1'b0;
        if (err_present) begin
            err_code_nxt = rotate(err_mask, err_code, err_run);
        end else if (warn_present) begin
            warn_show_nxt = ~warn_show;
            if (!warn_show) warn_code_nxt = rotate(warn_mask, warn_code, warn_run);
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            err_code  <= 4'd0;
            warn_code <= 4'd0;
            warn_show <= 1'b0;
            err_run   <= 1'b0;
            warn_run  <= 1'b0;
            msg_sel   <= MSG_NORMAL;
        end else if (tick) begin
            err_code  <= err_code_nxt;
            warn_code <= warn_code_nxt;
            warn_show <= warn_show_nxt;
            err_run   <= err_present;
            warn_run  <= !err_present && warn_present;
            if (err_present) msg_sel <= err_msg(err_code_nxt);
            else if (warn_show_nxt) msg_sel <= warn_msg(warn_code_nxt);
            else msg_sel <= MSG_NORMAL;
        end
    end

    // Screen choice moves only right after a display tick
    msg_sel_steady: assert property (@(posedge CLOCK_50) disable iff (rst)
        !$past(tick) && !$past(rst) |-> $stable(msg_sel));

endmodule

/* lcd_byte_writer.sv */
module lcd_byte_writer
    import lcd_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       rst,
    input  logic       wr_valid,
    input  logic       wr_rs,
    input  logic [7:0] wr_byte,
    output logic       credit_ret,
    output logic [7:0] lcd_data,
    output logic       lcd_rs,
    output logic       lcd_en
);

    typedef enum logic [1:0] {W_IDLE, W_SETUP, W_PULSE, W_GAP} wr_state_t;

    wr_state_t  state;
    logic [7:0] q_byte [WRITER_DEPTH];
    logic       q_rs   [WRITER_DEPTH];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic [7:0] timer;
    logic       is_clear;

    assign credit_ret = (state == W_GAP) && (timer == 8'd0);   // Head entry leaves
    assign is_clear   = !lcd_rs && (lcd_data == CMD_CLEAR);

    always_ff @(posedge CLOCK_50) begin
        if (wr_valid) begin
            q_byte[wr_ptr] <= wr_byte;
            q_rs[wr_ptr]   <= wr_rs;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (wr_valid) wr_ptr <= ~wr_ptr;
            if (credit_ret) rd_ptr <= ~rd_ptr;
            if (wr_valid && !credit_ret) count <= count + 2'd1;
            else if (!wr_valid && credit_ret) count <= count - 2'd1;
        end
    end

    // ===================================================================
    // Bus timing: setup, enable pulse, then command gap
    // ===================================================================
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            state  <= W_IDLE;
            timer  <= 8'd0;
            lcd_en <= 1'b0;
        end else begin
            case (state)
                W_IDLE: if (count != 2'd0) state <= W_SETUP;
                W_SETUP: begin
                    lcd_en <= 1'b1;
                    timer  <= EN_PULSE - 8'd1;
                    state  <= W_PULSE;
                end
                W_PULSE: begin
                    if (timer == 8'd0) begin
                        lcd_en <= 1'b0;
                        timer  <= is_clear ? CLEAR_GAP - 8'd1 : CMD_GAP - 8'd1;
                        state  <= W_GAP;
                    end else begin
                        timer <= timer - 8'd1;
                    end
                end
                default: begin
                    if (timer == 8'd0) state <= W_IDLE;
                    else timer <= timer - 8'd1;
                end
            endcase
        end
    end

    // Data and rs follow the head entry
    always_ff @(posedge CLOCK_50) begin
        if (state == W_IDLE && count != 2'd0) begin
            lcd_data <= q_byte[rd_ptr];
            lcd_rs   <= q_rs[rd_ptr];
        end
    end

    // Sender's credits must keep the queue from overflowing
    no_overflow: assert property (@(posedge CLOCK_50) disable iff (rst)
        wr_valid |-> count < WRITER_DEPTH);

endmodule

/* lcd_pkg.sv */
package lcd_pkg;

    // =====================================================================
    // Timing counts, scaled down for simulation
    // =====================================================================
    localparam logic [31:0] TICK_CYCLES    = 32'd2000;   // One display tick
    localparam logic [15:0] POWERUP_CYCLES = 16'd300;
    localparam logic [7:0]  EN_PULSE       = 8'd4;
    localparam logic [7:0]  CMD_GAP        = 8'd20;
    localparam logic [7:0]  CLEAR_GAP      = 8'd120;     // Clear is slow on the panel
    localparam logic [1:0]  WRITER_DEPTH   = 2'd2;       // Queue depth and initial credits
    localparam int          LINE_CHARS     = 16;

    // =====================================================================
    // LCD command bytes
    // =====================================================================
    localparam logic [7:0] CMD_FUNC_RESET = 8'h30;
    localparam logic [7:0] CMD_FUNC_SET   = 8'h38;       // 8-bit bus, two lines
    localparam logic [7:0] CMD_DISP_OFF   = 8'h08;
    localparam logic [7:0] CMD_CLEAR      = 8'h01;
    localparam logic [7:0] CMD_ENTRY      = 8'h06;
    localparam logic [7:0] CMD_DISP_ON    = 8'h0C;
    localparam logic [7:0] CMD_LINE1      = 8'h80;
    localparam logic [7:0] CMD_LINE2      = 8'hC0;

    // Error mask bits
    localparam logic [3:0] E_PAPER_NOT_INST = 4'd0;
    localparam logic [3:0] E_PAPER_EMPTY    = 4'd1;
    localparam logic [3:0] E_NO_COFFEE0     = 4'd2;
    localparam logic [3:0] E_NO_COFFEE1     = 4'd3;
    localparam logic [3:0] E_NO_CREAMER     = 4'd4;
    localparam logic [3:0] E_NO_CHOC        = 4'd5;
    localparam logic [3:0] E_PRESS_ERR      = 4'd6;
    localparam logic [3:0] E_PRESS_HIGH     = 4'd7;
    localparam logic [3:0] E_STATUS_ERR     = 4'd8;

    // Warning mask bits
    localparam logic [3:0] W_FILTER_ALMOST = 4'd0;
    localparam logic [3:0] W_LOW_PRESSURE  = 4'd1;
    localparam logic [3:0] W_BIN0_LOW      = 4'd2;
    localparam logic [3:0] W_BIN1_LOW      = 4'd3;
    localparam logic [3:0] W_ND_LOW        = 4'd4;
    localparam logic [3:0] W_CH_LOW        = 4'd5;

    localparam logic [1:0] LEVEL_ALMOST = 2'b10;
    localparam logic [1:0] PRESSURE_LOW = 2'b00;

    // =====================================================================
    // Message codes and system states
    // =====================================================================
    localparam logic [3:0] MSG_NORMAL         = 4'd0;
    localparam logic [3:0] MSG_FILTER_ALMOST  = 4'd1;
    localparam logic [3:0] MSG_PAPER_EMPTY    = 4'd2;
    localparam logic [3:0] MSG_PAPER_NOT_INST = 4'd3;
    localparam logic [3:0] MSG_BIN0_LOW       = 4'd4;
    localparam logic [3:0] MSG_BIN1_LOW       = 4'd5;
    localparam logic [3:0] MSG_ND_LOW         = 4'd6;
    localparam logic [3:0] MSG_CH_LOW         = 4'd7;
    localparam logic [3:0] MSG_PRESS_ERR      = 4'd8;
    localparam logic [3:0] MSG_PRESS_HIGH     = 4'd9;
    localparam logic [3:0] MSG_PRESS_LOW      = 4'd10;
    localparam logic [3:0] MSG_STATUS_ERR     = 4'd11;
    localparam logic [3:0] MSG_NO_COFFEE0     = 4'd12;
    localparam logic [3:0] MSG_NO_COFFEE1     = 4'd13;
    localparam logic [3:0] MSG_NO_CHOC        = 4'd14;
    localparam logic [3:0] MSG_NO_CREAMER     = 4'd15;

    localparam logic [1:0] ST_SELECT = 2'd0;
    localparam logic [1:0] ST_HEAT   = 2'd1;
    localparam logic [1:0] ST_BREW   = 2'd2;
    localparam logic [1:0] ST_READY  = 2'd3;

endpackage

/* lcd_status_top.sv */
module lcd_status_top (
    input  logic        CLOCK_50,
    input  logic        rst,
    input  logic [1:0]  paper_level,
    input  logic [1:0]  bin0_level,
    input  logic [1:0]  bin1_level,
    input  logic [1:0]  nd_level,
    input  logic [1:0]  ch_level,
    input  logic [1:0]  w_pressure,
    input  logic [15:0] err_mask,
    input  logic        cur_flavor,
    input  logic [2:0]  cur_type,
    input  logic [1:0]  cur_size,
    input  logic [1:0]  sys_state,
    output logic [7:0]  lcd_data,
    output logic        lcd_rs,
    output logic        lcd_en
);

    logic [3:0] msg_sel;       // Screen picked by the alert logic
    logic       line;
    logic [3:0] col;
    logic [7:0] char;
    logic       wr_valid;
    logic       wr_rs;
    logic [7:0] wr_byte;
    logic       credit_ret;

    // ===================================================================
    // Alert selection, text lookup, sequencing and bus drive
    // ===================================================================
    alert_cycler i_alert_cycler (.*);

    message_rom i_message_rom (.*);

    screen_sequencer i_screen_sequencer (.*);

    lcd_byte_writer i_lcd_byte_writer (.*);   // Credits flow back to the sequencer

endmodule

/* message_rom.sv */
module message_rom
    import lcd_pkg::*;
(
    input  logic [3:0] msg_sel,
    input  logic       line,
    input  logic [3:0] col,
    input  logic       cur_flavor,
    input  logic [2:0] cur_type,
    input  logic [1:0] cur_size,
    input  logic [1:0] sys_state,
    output logic [7:0] char
);

    logic [127:0] line_str;
    logic [7:0]   flavor_ch;

    function automatic logic [39:0] drink5(input logic [2:0] t);
        case (t)
            3'd0:    return "MOCHA";
            3'd1:    return "LATTE";
            3'd2:    return "ESPR ";
            3'd3:    return "AMER ";
            3'd4:    return "DRIP ";
            default: return "UNKN ";
        endcase
    endfunction

    function automatic logic [31:0] size4(input logic [1:0] s);
        case (s)
            2'd0:    return "10oz";
            2'd1:    return "16oz";
            2'd2:    return "20oz";
            default: return "??oz";
        endcase
    endfunction

    function automatic logic [127:0] state_word(input logic [1:0] st);
        case (st)
            ST_SELECT: return "Press START     ";
            ST_HEAT:   return "HEATING...      ";
            ST_BREW:   return "BREWING         ";
            default:   return "READY           ";
        endcase
    endfunction

    // ===================================================================
    // Fixed two-line messages, line 0 on the right of each pair
    // ===================================================================
    function automatic logic [127:0] fixed_line(input logic [3:0] sel, input logic ln);
        case (sel)
            MSG_FILTER_ALMOST:  return ln ? "st Empty        " : "Paper Filter Alm";
            MSG_PAPER_EMPTY:    return ln ? "Empty           " : "Paper Filter    ";
            MSG_PAPER_NOT_INST: return ln ? "INSTALLED       " : "Paper Filter NOT";
            MSG_BIN0_LOW:       return ln ? "st Empty        " : "Coffee Bin 0 Alm";
            MSG_BIN1_LOW:       return ln ? "st Empty        " : "Coffee Bin 1 Alm";
            MSG_ND_LOW:         return ln ? "lmst Empty      " : "Non-Dairy Crmr A";
            MSG_CH_LOW:         return ln ? "lmst Empty      " : "Chocolate Pwdr A";
            MSG_PRESS_ERR:      return ln ? "Error!          " : "Water Pressure  ";
            MSG_PRESS_HIGH:     return ln ? "Pressure        " : "High Water      ";
            MSG_PRESS_LOW:      return ln ? "Pressure        " : "Low Water       ";
            MSG_STATUS_ERR:     return ln ? "Error - Service " : "Hardware Status ";
            MSG_NO_COFFEE0:     return ln ? "Cannot execute  " : "No Coffee Bin 0 ";
            MSG_NO_COFFEE1:     return ln ? "Cannot execute  " : "No Coffee Bin 1 ";
            MSG_NO_CHOC:        return ln ? "Cannot execute  " : "No Chocolate    ";
            default:            return ln ? "Cannot execute  " : "No Creamer      ";
        endcase
    endfunction

    assign flavor_ch = cur_flavor ? "2" : "1";

    always_comb begin
        if (msg_sel != MSG_NORMAL) begin
            line_str = fixed_line(msg_sel, line);
        end else if (line) begin
            line_str = state_word(sys_state);
        end else begin
            // Selection line, e.g. "C1 LATTE 16oz"
            line_str = {"C", flavor_ch, " ", drink5(cur_type), " ", size4(cur_size), "   "};
        end
    end

    // First character sits in the top byte
    assign char = line_str[8 * (LINE_CHARS - 1 - int'(col)) +: 8];

endmodule

/* screen_sequencer.sv */
module screen_sequencer
    import lcd_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       rst,
    input  logic [3:0] msg_sel,
    input  logic       cur_flavor,
    input  logic [2:0] cur_type,
    input  logic [1:0] cur_size,
    input  logic [1:0] sys_state,
    input  logic [7:0] char,
    input  logic       credit_ret,
    output logic       line,
    output logic [3:0] col,
    output logic       wr_valid,
    output logic       wr_rs,
    output logic [7:0] wr_byte
);

    typedef enum logic [2:0] {
        S_PWRUP, S_INIT, S_L1_ADDR, S_L1_CHARS, S_L2_ADDR, S_L2_CHARS, S_IDLE
    } seq_state_t;

    seq_state_t  state;
    logic [15:0] wait_cnt;
    logic [3:0]  idx;            // Init step or column
    logic [1:0]  credits;
    logic        init_last;
    logic        col_last;
    logic        changed;
    logic        pending;
    logic [3:0]  prev_msg;
    logic        prev_flavor;
    logic [2:0]  prev_type;
    logic [1:0]  prev_size;
    logic [1:0]  prev_state;

    function automatic logic [7:0] init_cmd(input logic [3:0] step);
        case (step)
            4'd0, 4'd1, 4'd2: return CMD_FUNC_RESET;
            4'd3:             return CMD_FUNC_SET;
            4'd4:             return CMD_DISP_OFF;
            4'd5:             return CMD_CLEAR;
            4'd6:             return CMD_ENTRY;
            default:          return CMD_DISP_ON;
        endcase
    endfunction

    assign line      = (state == S_L2_CHARS);
    assign col       = idx;
    assign init_last = (idx == 4'd7);
    assign col_last  = (idx == 4'(LINE_CHARS - 1));

    // One write per cycle while credits remain
    assign wr_valid = (credits != 2'd0) && (state != S_PWRUP) && (state != S_IDLE || pending);

    always_comb begin
        wr_rs   = 1'b0;
        wr_byte = CMD_CLEAR;               // Idle redraw opens with a clear
        case (state)
            S_INIT:    wr_byte = init_cmd(idx);
            S_L1_ADDR: wr_byte = CMD_LINE1;
            S_L2_ADDR: wr_byte = CMD_LINE2;
            S_L1_CHARS, S_L2_CHARS: begin
                wr_rs   = 1'b1;
                wr_byte = char;
            end
            default:   wr_byte = CMD_CLEAR;
        endcase
    end

    // ===================================================================
    // Change detection
    // ===================================================================
    assign changed = (msg_sel != prev_msg) || (cur_flavor != prev_flavor) ||
                     (cur_type != prev_type) || (cur_size != prev_size) ||
                     (sys_state != prev_state);

    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            prev_msg    <= MSG_NORMAL;
            prev_flavor <= 1'b0;
            prev_type   <= 3'd0;
            prev_size   <= 2'd0;
            prev_state  <= ST_SELECT;
            pending     <= 1'b0;
        end else begin
            prev_msg    <= msg_sel;
            prev_flavor <= cur_flavor;
            prev_type   <= cur_type;
            prev_size   <= cur_size;
            prev_state  <= sys_state;
            if (changed) pending <= 1'b1;
            else if (wr_valid && (state == S_IDLE || (state == S_INIT && init_last)))
                pending <= 1'b0;           // First screen already reads fresh inputs
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rst) credits <= WRITER_DEPTH;
        else if (wr_valid && !credit_ret) credits <= credits - 2'd1;
        else if (!wr_valid && credit_ret) credits <= credits + 2'd1;
    end

    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            state    <= S_PWRUP;
            wait_cnt <= 16'd0;
            idx      <= 4'd0;
        end else begin
            case (state)
                S_PWRUP: begin
                    if (wait_cnt == POWERUP_CYCLES - 16'd1) state <= S_INIT;
                    else wait_cnt <= wait_cnt + 16'd1;
                end
                S_INIT: begin
                    if (wr_valid) begin
                        idx <= init_last ? 4'd0 : idx + 4'd1;
                        if (init_last) state <= S_L1_ADDR;
                    end
                end
                S_L1_ADDR: if (wr_valid) state <= S_L1_CHARS;
                S_L1_CHARS: begin
                    if (wr_valid) begin
                        idx <= idx + 4'd1;     // Wraps to 0 after the last column
                        if (col_last) state <= S_L2_ADDR;
                    end
                end
                S_L2_ADDR: if (wr_valid) state <= S_L2_CHARS;
                S_L2_CHARS: begin
                    if (wr_valid) begin
                        idx <= idx + 4'd1;
                        if (col_last) state <= S_IDLE;
                    end
                end
                S_IDLE: if (wr_valid) state <= S_L1_ADDR;
                default: state <= S_PWRUP;
            endcase
        end
    end

    credit_bound: assert property (@(posedge CLOCK_50) disable iff (rst)
        credits <= WRITER_DEPTH);

endmodule

/* src.f */
lcd_pkg.sv
alert_cycler.sv
message_rom.sv
screen_sequencer.sv
lcd_byte_writer.sv
lcd_status_top.sv
tb_lcd_status.sv

/* tb_lcd_status.sv */
module tb_lcd_status
    import lcd_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD  = 4;
    localparam int unsigned SEED        = 37550;
    localparam longint      WATCHDOG_NS = 40 * longint'(TICK_CYCLES) * CLK_PERIOD;
    localparam logic [1:0]  LEVEL_OK    = 2'b11;
    localparam logic [1:0]  PRESSURE_OK = 2'b01;

    logic        CLOCK_50 = 1'b0;
    logic        rst;
    logic [1:0]  paper_level;
    logic [1:0]  bin0_level;
    logic [1:0]  bin1_level;
    logic [1:0]  nd_level;
    logic [1:0]  ch_level;
    logic [1:0]  w_pressure;
    logic [15:0] err_mask;
    logic        cur_flavor;
    logic [2:0]  cur_type;
    logic [1:0]  cur_size;
    logic [1:0]  sys_state;
    logic [7:0]  lcd_data;
    logic        lcd_rs;
    logic        lcd_en;

    // Bus monitor state
    logic         en_d;
    int           since_rise;      // Cycles since the last enable rise
    logic         seen_rise;
    logic         prev_clear;
    logic [8:0]   byte_log [$];    // {rs, data} per enable pulse
    logic [256:0] screen_q [$];    // {clear seen, line 0, line 1}
    int           asm_phase = 0;
    int           asm_col = 0;
    logic [127:0] asm_l0;
    logic [127:0] asm_l1;
    logic         clear_seen = 1'b0;

    // =====================================================================
    // Screen model
    // =====================================================================
    string err_lines [18] = '{
        "Paper Filter NOT", "INSTALLED",
        "Paper Filter",     "Empty",
        "No Coffee Bin 0",  "Cannot execute",
        "No Coffee Bin 1",  "Cannot execute",
        "No Creamer",       "Cannot execute",
        "No Chocolate",     "Cannot execute",
        "Water Pressure",   "Error!",
        "High Water",       "Pressure",
        "Hardware Status",  "Error - Service"
    };
    string warn_lines [12] = '{
        "Paper Filter Alm", "st Empty",
        "Low Water",        "Pressure",
        "Coffee Bin 0 Alm", "st Empty",
        "Coffee Bin 1 Alm", "st Empty",
        "Non-Dairy Crmr A", "lmst Empty",
        "Chocolate Pwdr A", "lmst Empty"
    };
    string drink_names [8] = '{"MOCHA", "LATTE", "ESPR ", "AMER ",
                               "DRIP ", "UNKN ", "UNKN ", "UNKN "};
    string size_names [4]  = '{"10oz", "16oz", "20oz", "??oz"};
    string state_words [4] = '{"Press START", "HEATING...", "BREWING", "READY"};
    logic [7:0] init_cmds [9] = '{CMD_FUNC_RESET, CMD_FUNC_RESET, CMD_FUNC_RESET,
                                  CMD_FUNC_SET, CMD_DISP_OFF, CMD_CLEAR, CMD_ENTRY,
                                  CMD_DISP_ON, CMD_LINE1};

    always #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;

    lcd_status_top i_lcd_status_top (.*);

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string sig, input string exp, input string act);
        stop_with_error($sformatf("MISMATCH time=%0t signal=%s expected=%s actual=%s",
                                  $time, sig, exp, act));
    endtask

    // Space padded to one display line
    function automatic logic [127:0] pack16(input string s);
        logic [127:0] r;
        r = {16{8'h20}};
        for (int i = 0; i < s.len() && i < LINE_CHARS; i++) begin
            r[8 * (LINE_CHARS - 1 - i) +: 8] = s[i];
        end
        return r;
    endfunction

    function automatic string normal_line0(input logic fl, input logic [2:0] t,
                                           input logic [1:0] sz);
        return $sformatf("C%0d %s %s", int'(fl) + 1, drink_names[t], size_names[sz]);
    endfunction

    // Rebuilds screens from the byte stream
    task automatic log_byte(input logic rs, input logic [7:0] b);
        byte_log.push_back({rs, b});
        if (!rs) begin
            if (b == CMD_CLEAR) clear_seen = 1'b1;
            if (b == CMD_LINE1) begin
                asm_phase = 1;
                asm_col   = 0;
            end else if (b == CMD_LINE2 && asm_phase == 2) begin
                asm_phase = 3;
                asm_col   = 0;
            end else begin
                asm_phase = 0;
            end
        end else if (asm_phase == 1 || asm_phase == 3) begin
            if (asm_phase == 1) asm_l0[8 * (LINE_CHARS - 1 - asm_col) +: 8] = b;
            else asm_l1[8 * (LINE_CHARS - 1 - asm_col) +: 8] = b;
            asm_col++;
            if (asm_col == LINE_CHARS && asm_phase == 3) begin
                screen_q.push_back({clear_seen, asm_l0, asm_l1});
                clear_seen = 1'b0;
                asm_phase  = 0;
            end else if (asm_col == LINE_CHARS) begin
                asm_phase = 2;             // Line 2 address next
            end
        end else begin
            asm_phase = 0;
        end
    endtask

    always @(posedge CLOCK_50) begin
        en_d <= lcd_en;
        if (rst) begin
            since_rise <= 0;
            seen_rise  <= 1'b0;
            prev_clear <= 1'b0;
        end else if (lcd_en && !en_d) begin
            since_rise <= 1;
            seen_rise  <= 1'b1;
            prev_clear <= !lcd_rs && (lcd_data == CMD_CLEAR);
            log_byte(lcd_rs, lcd_data);
        end else if (since_rise < 1000) begin
            since_rise <= since_rise + 1;
        end
    end

    task automatic check_screen(input string exp0, input string exp1, input string what);
        logic [256:0] scr;
        while (screen_q.size() == 0) @(posedge CLOCK_50);
        scr = screen_q.pop_front();
        assert (scr[256])
            else stop_with_error({"No CLEAR came before the ", what, " screen"});
        assert (scr[255:128] == pack16(exp0))
            else value_mismatch({what, " line 0"}, $sformatf("\"%s\"", pack16(exp0)),
                                $sformatf("\"%s\"", scr[255:128]));
        assert (scr[127:0] == pack16(exp1))
            else value_mismatch({what, " line 1"}, $sformatf("\"%s\"", pack16(exp1)),
                                $sformatf("\"%s\"", scr[127:0]));
    endtask

    // =====================================================================
    // Stimulus
    // =====================================================================
    initial begin
        int unsigned new_size;
        int unsigned b0;
        int unsigned b1;
        int unsigned lo;
        int unsigned hi;
        int unsigned w;
        void'($urandom(SEED));
        rst         = 1'b1;
        paper_level = LEVEL_OK;
        bin0_level  = LEVEL_OK;
        bin1_level  = LEVEL_OK;
        nd_level    = LEVEL_OK;
        ch_level    = LEVEL_OK;
        w_pressure  = PRESSURE_OK;
        err_mask    = 16'd0;
        cur_flavor  = 1'($urandom_range(1));
        cur_type    = 3'($urandom_range(7));
        cur_size    = 2'($urandom_range(3));
        sys_state   = 2'($urandom_range(3));
        for (int i = 0; i < 5; i++) begin
            @(posedge CLOCK_50);
            if (i > 0) begin
                assert (lcd_en === 1'b0)
                    else value_mismatch("lcd_en", "0", $sformatf("%b", lcd_en));
            end
        end
        rst <= 1'b0;

        check_screen(normal_line0(cur_flavor, cur_type, cur_size), state_words[sys_state],
                     "first");
        for (int i = 0; i < 9; i++) begin
            assert (byte_log[i] == {1'b0, init_cmds[i]})
                else value_mismatch($sformatf("init byte %0d {lcd_rs, lcd_data}", i),
                                    $sformatf("%03h", {1'b0, init_cmds[i]}),
                                    $sformatf("%03h", byte_log[i]));
        end

        // New cup size while idle
        new_size = (int'(cur_size) + 1 + $urandom_range(2)) % 4;
        @(posedge CLOCK_50);
        cur_size <= 2'(new_size);
        check_screen(normal_line0(cur_flavor, cur_type, 2'(new_size)),
                     state_words[sys_state], "resized");

        b0 = $urandom_range(8);
        b1 = (b0 + 1 + $urandom_range(7)) % 9;
        lo = (b0 < b1) ? b0 : b1;
        hi = (b0 < b1) ? b1 : b0;
        @(posedge CLOCK_50);
        err_mask <= 16'((32'd1 << b0) | (32'd1 << b1));
        check_screen(err_lines[2 * lo], err_lines[2 * lo + 1], "lower error");
        check_screen(err_lines[2 * hi], err_lines[2 * hi + 1], "upper error");
        check_screen(err_lines[2 * lo], err_lines[2 * lo + 1], "wrapped error");

        // One level near empty, indexed like the warning bits
        w = $urandom_range(5);
        @(posedge CLOCK_50);
        err_mask <= 16'd0;
        case (w)
            0: paper_level <= LEVEL_ALMOST;
            1: w_pressure <= PRESSURE_LOW;
            2: bin0_level <= LEVEL_ALMOST;
            3: bin1_level <= LEVEL_ALMOST;
            4: nd_level <= LEVEL_ALMOST;
            default: ch_level <= LEVEL_ALMOST;
        endcase
        check_screen(warn_lines[2 * w], warn_lines[2 * w + 1], "warning");
        check_screen(normal_line0(cur_flavor, cur_type, 2'(new_size)),
                     state_words[sys_state], "normal between warnings");
        check_screen(warn_lines[2 * w], warn_lines[2 * w + 1], "repeated warning");

        $display("Verification passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_error("Watchdog expired before all screens were checked");
    end

    // =====================================================================
    // Bus timing
    // =====================================================================
    bus_spacing: assert property (@(posedge CLOCK_50) disable iff (rst)
        (lcd_en && !en_d && seen_rise) |->
            since_rise >= (prev_clear ? EN_PULSE + CLEAR_GAP : EN_PULSE + CMD_GAP))
        else value_mismatch("lcd_en rise spacing",
                            $sformatf(">= %0d", $sampled(prev_clear) ?
                                      EN_PULSE + CLEAR_GAP : EN_PULSE + CMD_GAP),
                            $sformatf("%0d", $sampled(since_rise)));

    en_pulse_width: assert property (@(posedge CLOCK_50) disable iff (rst)
        $rose(lcd_en) |-> lcd_en [*EN_PULSE] ##1 !lcd_en)
        else stop_with_error($sformatf("lcd_en pulse near %0t was not %0d cycles long",
                                       $time, EN_PULSE));

endmodule
